// File: hw/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// bus address width
`define UART_ADDR_W     12

// register offsets
`define DATA_REG_ADDR   12'h000
`define UART_CSR_ADDR   12'h004
`define UART_CTRL_ADDR  12'h008

// bit divisor width and reset value, one bit is divisor+1 cycles
`define UART_DIV_W      12
`define UART_DIV_DFT    12'd15

// reset values, only the csr divisor field is nonzero
`define UART_CSR_DFT    {12'h000, `UART_DIV_DFT, 8'h00}
`define UART_CTRL_DFT   32'h0000_0000

`endif

// File: hw/uart_bus_pkg.sv
`include "uart_cfg.svh"

package uart_bus_pkg;

	// command channel payload
	typedef struct packed {
		logic [`UART_ADDR_W-1:0] addr;
		logic                    read;
		logic [31:0]             wdata;
	} bus_cmd_t;

	// response channel payload, zero for writes
	typedef struct packed {
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

// File: hw/uart_reg_pkg.sv
`include "uart_cfg.svh"

package uart_reg_pkg;

	// control register
	typedef struct packed {
		logic [26:0] rsvd;
		logic        irq_en;
		logic        parity_odd;
		logic        parity_en;
		logic        rx_en;
		logic        tx_en;
	} uart_ctrl_t;

	// csr as seen by a write
	typedef struct packed {
		logic [11:0]            user;
		logic [`UART_DIV_W-1:0] divisor;
		logic [7:0]             ignored;
	} csr_wr_t;

	// csr as seen by a read
	typedef struct packed {
		logic                   parity_error;
		logic [10:0]            rsvd_hi;
		logic [`UART_DIV_W-1:0] divisor;
		logic [2:0]             rsvd_mid;
		logic                   rx_ok;
		logic [2:0]             rsvd_lo;
		logic                   tx_ok;
	} csr_rd_t;

	// one csr word, config on write and status on read
	typedef union packed {
		csr_wr_t wr;
		csr_rd_t rd;
	} uart_csr_u;

	// frame setup shared by transmitter and receiver
	typedef struct packed {
		logic [`UART_DIV_W-1:0] divisor;
		logic                   parity_en;
		logic                   parity_odd;
	} line_cfg_t;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       parity_error;
	} rx_stat_t;

endpackage

// File: hw/uart_ctrl.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_ctrl
	import uart_bus_pkg::*, uart_reg_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_cmd_valid,
	input  bus_cmd_t   i_cmd,
	output logic       o_cmd_ready,
	output logic       o_rsp_valid,
	output bus_rsp_t   o_rsp,
	input  logic       i_rsp_ready,
	output line_cfg_t  o_line_cfg,
	output logic       o_tx_start,
	output logic [7:0] o_tx_data,
	input  logic       i_tx_busy,
	input  rx_stat_t   i_rx_stat,
	output logic       o_rx_clear,
	output logic       o_irq
);

	uart_ctrl_t  ctrl_q;
	uart_csr_u   csr_q;
	uart_csr_u   csr_wr_word;
	uart_csr_u   csr_rd_word;
	logic        ready_en;
	logic        cmd_fire;
	logic        wr_fire;
	logic        rd_fire;
	logic        tx_wr;
	logic        rx_ok;
	logic        tx_ok;
	logic [31:0] rd_data;

	// one transfer in flight, ready again as the response leaves
	assign o_cmd_ready = ready_en & (~o_rsp_valid | i_rsp_ready);
	assign cmd_fire = i_cmd_valid & o_cmd_ready;
	assign wr_fire = cmd_fire & ~i_cmd.read;
	assign rd_fire = cmd_fire & i_cmd.read;
	assign tx_wr = wr_fire & (i_cmd.addr == `DATA_REG_ADDR) & ctrl_q.tx_en;

	assign rx_ok = i_rx_stat.valid & ctrl_q.rx_en;
	// a start still on its way to the transmitter counts as busy
	assign tx_ok = ~(i_tx_busy | o_tx_start);

	assign csr_wr_word = i_cmd.wdata;

	always_comb begin
		csr_rd_word.rd = '0;
		csr_rd_word.rd.parity_error = i_rx_stat.parity_error;
		csr_rd_word.rd.divisor = csr_q.wr.divisor;
		csr_rd_word.rd.rx_ok = rx_ok;
		csr_rd_word.rd.tx_ok = tx_ok;
	end

	// unmapped offsets read as zero
	always_comb begin
		case (i_cmd.addr)
			`DATA_REG_ADDR:  rd_data = {24'h0, i_rx_stat.data};
			`UART_CSR_ADDR:  rd_data = csr_rd_word;
			`UART_CTRL_ADDR: rd_data = ctrl_q;
			default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_en <= 1'b0;
			o_rsp_valid <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			if (cmd_fire) begin
				o_rsp_valid <= 1'b1;
			end else if (i_rsp_ready) begin
				o_rsp_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			o_rsp.rdata <= i_cmd.read ? rd_data : 32'h0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= `UART_CTRL_DFT;
			csr_q <= `UART_CSR_DFT;
			o_tx_start <= 1'b0;
		end else begin
			o_tx_start <= tx_wr;
			if (wr_fire) begin
				case (i_cmd.addr)
					`UART_CSR_ADDR:  csr_q.wr.divisor <= csr_wr_word.wr.divisor;
					`UART_CTRL_ADDR: ctrl_q <= i_cmd.wdata;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx_wr) begin
			o_tx_data <= i_cmd.wdata[7:0];
		end
	end

	assign o_line_cfg = '{
		divisor:    csr_q.wr.divisor,
		parity_en:  ctrl_q.parity_en,
		parity_odd: ctrl_q.parity_odd
	};

	// data read consumes the byte, a disabled receiver keeps its flags clear
	assign o_rx_clear = (rd_fire & (i_cmd.addr == `DATA_REG_ADDR)) | ~ctrl_q.rx_en;
	assign o_irq = ctrl_q.irq_en & rx_ok;

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx
	import uart_reg_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  line_cfg_t  i_line_cfg,
	input  logic       i_start,
	input  logic [7:0] i_data,
	output logic       o_busy,
	output logic       o_txd
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	tx_state_e              state;
	logic [`UART_DIV_W-1:0] bit_cnt;
	logic [2:0]             bit_idx;
	logic [7:0]             shift_q;
	logic                   par_q;
	logic                   bit_end;

	assign bit_end = (bit_cnt == i_line_cfg.divisor);
	assign o_busy = (state != TX_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			o_txd <= 1'b1;
		end else if (state == TX_IDLE) begin
			bit_cnt <= '0;
			// starts while busy never get here
			if (i_start) begin
				state <= TX_START;
				o_txd <= 1'b0;
			end
		end else if (!bit_end) begin
			bit_cnt <= bit_cnt + 1'b1;
		end else begin
			bit_cnt <= '0;
			case (state)
				TX_START: begin
					state <= TX_DATA;
					bit_idx <= '0;
					o_txd <= shift_q[0];
				end
				TX_DATA: begin
					if (bit_idx == 3'd7) begin
						state <= i_line_cfg.parity_en ? TX_PARITY : TX_STOP;
						o_txd <= i_line_cfg.parity_en ? par_q : 1'b1;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						o_txd <= shift_q[0];
					end
				end
				TX_PARITY: begin
					state <= TX_STOP;
					o_txd <= 1'b1;
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// byte and parity captured at frame start, lsb shifted out first
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_start) begin
			shift_q <= i_data;
			par_q <= ^i_data ^ i_line_cfg.parity_odd;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx
	import uart_reg_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  line_cfg_t i_line_cfg,
	input  logic      i_rxd,
	input  logic      i_clear,
	output rx_stat_t  o_stat
);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	rx_state_e              state;
	logic                   rxd_s1;
	logic                   rxd_s2;
	logic                   rxd_d;
	logic [`UART_DIV_W-1:0] bit_cnt;
	logic [2:0]             bit_idx;
	logic [7:0]             shift_q;
	logic                   par_bit;
	logic [7:0]             data_q;
	logic                   valid_q;
	logic                   perr_q;
	logic                   start_edge;
	logic                   half_pt;
	logic                   full_pt;
	logic                   stop_smp;

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_d <= 1'b1;
		end else begin
			rxd_s1 <= i_rxd;
			rxd_s2 <= rxd_s1;
			rxd_d <= rxd_s2;
		end
	end

	assign start_edge = rxd_d & ~rxd_s2;
	assign half_pt = (bit_cnt == (i_line_cfg.divisor >> 1));
	assign full_pt = (bit_cnt == i_line_cfg.divisor);
	assign stop_smp = (state == RX_STOP) & full_pt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (state == RX_IDLE) begin
			bit_cnt <= '0;
			if (start_edge) begin
				state <= RX_START;
			end
		end else if (state == RX_START) begin
			// middle of start bit, high here means a glitch
			if (half_pt) begin
				bit_cnt <= '0;
				bit_idx <= '0;
				state <= rxd_s2 ? RX_IDLE : RX_DATA;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else if (!full_pt) begin
			bit_cnt <= bit_cnt + 1'b1;
		end else begin
			bit_cnt <= '0;
			case (state)
				RX_DATA: begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= i_line_cfg.parity_en ? RX_PARITY : RX_STOP;
					end
				end
				RX_PARITY: state <= RX_STOP;
				default:   state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && full_pt) begin
			shift_q <= {rxd_s2, shift_q[7:1]};
		end
		if (state == RX_PARITY && full_pt) begin
			par_bit <= rxd_s2;
		end
		if (stop_smp) begin
			data_q <= shift_q;
		end
	end

	// new frame wins over a clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			perr_q <= 1'b0;
		end else if (stop_smp) begin
			valid_q <= 1'b1;
			perr_q <= i_line_cfg.parity_en &
				(^shift_q ^ par_bit ^ i_line_cfg.parity_odd);
		end else if (i_clear) begin
			valid_q <= 1'b0;
			perr_q <= 1'b0;
		end
	end

	assign o_stat = '{data: data_q, valid: valid_q, parity_error: perr_q};

endmodule

// File: hw/uart_top.sv
`timescale 1ns/100ps

module uart_top
	import uart_bus_pkg::*, uart_reg_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     i_cmd_valid,
	input  bus_cmd_t i_cmd,
	output logic     o_cmd_ready,
	output logic     o_rsp_valid,
	output bus_rsp_t o_rsp,
	input  logic     i_rsp_ready,
	output logic     o_txd,
	input  logic     i_rxd,
	output logic     o_irq
);

	line_cfg_t  line_cfg;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_busy;
	rx_stat_t   rx_stat;
	logic       rx_clear;

	uart_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd       (i_cmd),
		.o_cmd_ready (o_cmd_ready),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp       (o_rsp),
		.i_rsp_ready (i_rsp_ready),
		.o_line_cfg  (line_cfg),
		.o_tx_start  (tx_start),
		.o_tx_data   (tx_data),
		.i_tx_busy   (tx_busy),
		.i_rx_stat   (rx_stat),
		.o_rx_clear  (rx_clear),
		.o_irq       (o_irq)
	);

	uart_tx u_tx (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_line_cfg (line_cfg),
		.i_start    (tx_start),
		.i_data     (tx_data),
		.o_busy     (tx_busy),
		.o_txd      (o_txd)
	);

	uart_rx u_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_line_cfg (line_cfg),
		.i_rxd      (i_rxd),
		.i_clear    (rx_clear),
		.o_stat     (rx_stat)
	);

endmodule

// File: dv/uart_chk.sv
`timescale 1ns/100ps

module uart_chk
	import uart_bus_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     i_cmd_valid,
	input bus_cmd_t i_cmd,
	input logic     i_cmd_ready,
	input logic     i_rsp_valid,
	input bus_rsp_t i_rsp,
	input logic     i_rsp_ready,
	input logic     i_tx_busy,
	input logic     i_txd
);

	// a waiting command must not change
	property cmd_held;
		@(posedge clk) disable iff (!rst_n)
		i_cmd_valid && !i_cmd_ready |=> i_cmd_valid && $stable(i_cmd);
	endproperty

	property rsp_held;
		@(posedge clk) disable iff (!rst_n)
		i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp);
	endproperty

	// idle line is high
	property txd_idle;
		@(posedge clk) disable iff (!rst_n)
		!i_tx_busy |-> i_txd;
	endproperty

	a_cmd_held: assert property (cmd_held) else $error("command changed before acceptance");
	a_rsp_held: assert property (rsp_held) else $error("response dropped before taken");
	a_txd_idle: assert property (txd_idle) else $error("txd low while transmitter idle");

endmodule

bind uart_top uart_chk i_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_cmd_valid (i_cmd_valid),
	.i_cmd       (i_cmd),
	.i_cmd_ready (o_cmd_ready),
	.i_rsp_valid (o_rsp_valid),
	.i_rsp       (o_rsp),
	.i_rsp_ready (i_rsp_ready),
	.i_tx_busy   (tx_busy),
	.i_txd       (o_txd)
);

// File: dv/uart_tb.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tb
	import uart_bus_pkg::*;
();

	localparam int loop_div = 3;
	localparam int bit_cyc = loop_div + 1;
	// start bit is index 0, data 1 to 8, parity 9
	localparam int par_bit = 9;

	localparam logic [31:0] ctrl_tx = 32'h01;
	localparam logic [31:0] ctrl_rx = 32'h02;
	localparam logic [31:0] ctrl_pen = 32'h04;
	localparam logic [31:0] ctrl_podd = 32'h08;
	localparam logic [31:0] ctrl_irq = 32'h10;
	localparam logic wr = 1'b0;
	localparam logic rd = 1'b1;

	typedef struct packed {
		logic [`UART_ADDR_W-1:0] addr;
		logic                    rd;
		logic [31:0]             wdata;
		logic                    frame;
		logic                    corrupt;
		logic [31:0]             exp;
		logic                    irq_chk;
		logic                    irq_exp;
		logic [3:0]              hold;
		logic [7:0]              settle;
	} test_t;

	logic     clk;
	logic     rst_n;
	logic     cmd_valid;
	bus_cmd_t cmd;
	logic     cmd_ready;
	logic     rsp_valid;
	bus_rsp_t rsp;
	logic     rsp_ready;
	logic     txd;
	logic     rxd;
	logic     irq;

	logic       flip_en;
	logic       frame_on;
	int         line_cyc;
	test_t      tests[$];
	string      names[$];
	logic [7:0] rnd[8];
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	int         cycles = 0;
	int         limit = 0;

	uart_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.o_cmd_ready (cmd_ready),
		.o_rsp_valid (rsp_valid),
		.o_rsp       (rsp),
		.i_rsp_ready (rsp_ready),
		.o_txd       (txd),
		.i_rxd       (rxd),
		.o_irq       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// loopback, inverts the parity bit of a frame when asked
	assign rxd = txd ^ (flip_en & frame_on & ((line_cyc / bit_cyc) == par_bit));

	// cycles since the start edge seen on txd
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_on <= 1'b0;
			line_cyc <= 0;
		end else if (!frame_on) begin
			if (!txd) begin
				frame_on <= 1'b1;
				line_cyc <= 1;
			end
		end else if (line_cyc == 10 * bit_cyc - 1) begin
			frame_on <= 1'b0;
		end else begin
			line_cyc <= line_cyc + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// csr status word as laid out in the register map
	function automatic logic [31:0] csr_view(input logic perr, input logic rx_ok,
			input logic tx_ok);
		csr_view = {perr, 11'h0, 12'(loop_div), 3'h0, rx_ok, 3'h0, tx_ok};
	endfunction

	task automatic add_test(input string name, input logic [`UART_ADDR_W-1:0] addr,
			input logic is_rd, input logic [31:0] wdata, input logic frame,
			input logic corrupt, input logic [31:0] exp);
		test_t t;
		t = '0;
		t.addr = addr;
		t.rd = is_rd;
		t.wdata = wdata;
		t.frame = frame;
		t.corrupt = corrupt;
		t.exp = exp;
		tests.push_back(t);
		names.push_back(name);
	endtask

	task automatic extend_last(input logic irq_chk, input logic irq_exp, input int hold,
			input int settle);
		test_t t;
		t = tests.pop_back();
		t.irq_chk = irq_chk;
		t.irq_exp = irq_exp;
		t.hold = 4'(hold);
		t.settle = 8'(settle);
		tests.push_back(t);
	endtask

	task automatic build_table;
		add_test("ctrl_wr", `UART_CTRL_ADDR, wr, ctrl_tx | ctrl_rx, 1'b0, 1'b0, 32'h0);
		add_test("ctrl_rd", `UART_CTRL_ADDR, rd, 32'h0, 1'b0, 1'b0, ctrl_tx | ctrl_rx);
		add_test("csr_wr", `UART_CSR_ADDR, wr, {12'habc, 12'(loop_div), 8'h55}, 1'b0, 1'b0,
			32'h0);
		add_test("csr_rd", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 0, 1));
		add_test("unmapped_rd", 12'h00c, rd, 32'h0, 1'b0, 1'b0, 32'h0);
		add_test("unmapped_wr", 12'h010, wr, 32'hffff_ffff, 1'b0, 1'b0, 32'h0);
		add_test("unmapped_rd2", 12'h010, rd, 32'h0, 1'b0, 1'b0, 32'h0);
		add_test("loop_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[0]}, 1'b1, 1'b0, 32'h0);
		add_test("loop_csr_ok", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 1, 1));
		add_test("loop_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[0]});
		add_test("loop_csr_clr", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 0, 1));
		add_test("par_even_cfg", `UART_CTRL_ADDR, wr, ctrl_tx | ctrl_rx | ctrl_pen, 1'b0, 1'b0,
			32'h0);
		add_test("par_even_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[1]}, 1'b1, 1'b0, 32'h0);
		add_test("par_even_csr", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 1, 1));
		add_test("par_even_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[1]});
		add_test("par_odd_cfg", `UART_CTRL_ADDR, wr, ctrl_tx | ctrl_rx | ctrl_pen | ctrl_podd,
			1'b0, 1'b0, 32'h0);
		add_test("par_odd_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[2]}, 1'b1, 1'b0, 32'h0);
		add_test("par_odd_csr", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 1, 1));
		add_test("par_odd_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[2]});
		add_test("par_bad_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[3]}, 1'b1, 1'b1, 32'h0);
		add_test("par_bad_csr", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(1, 1, 1));
		add_test("par_bad_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[3]});
		add_test("par_bad_clr", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 0, 1));
		add_test("irq_cfg", `UART_CTRL_ADDR, wr, ctrl_tx | ctrl_rx | ctrl_irq, 1'b0, 1'b0,
			32'h0);
		extend_last(1'b1, 1'b0, 0, 0);
		add_test("irq_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[4]}, 1'b1, 1'b0, 32'h0);
		extend_last(1'b1, 1'b1, 0, 0);
		add_test("irq_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[4]});
		extend_last(1'b1, 1'b0, 0, 0);
		add_test("noirq_cfg", `UART_CTRL_ADDR, wr, ctrl_tx | ctrl_rx, 1'b0, 1'b0, 32'h0);
		add_test("noirq_tx", `DATA_REG_ADDR, wr, {24'h0, rnd[5]}, 1'b1, 1'b0, 32'h0);
		extend_last(1'b1, 1'b0, 0, 0);
		add_test("noirq_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[5]});
		add_test("bp_rd", `UART_CTRL_ADDR, rd, 32'h0, 1'b0, 1'b0, ctrl_tx | ctrl_rx);
		extend_last(1'b0, 1'b0, 6, 0);
		// second byte lands while the first frame is on the line
		add_test("busy_tx1", `DATA_REG_ADDR, wr, {24'h0, rnd[6]}, 1'b0, 1'b0, 32'h0);
		add_test("busy_tx2", `DATA_REG_ADDR, wr, {24'h0, rnd[7]}, 1'b1, 1'b0, 32'h0);
		add_test("busy_rd", `DATA_REG_ADDR, rd, 32'h0, 1'b0, 1'b0, {24'h0, rnd[6]});
		add_test("busy_idle", `UART_CSR_ADDR, rd, 32'h0, 1'b0, 1'b0, csr_view(0, 0, 1));
		extend_last(1'b0, 1'b0, 0, 12 * bit_cyc);
	endtask

	// one command and its response, response held back for t.hold cycles
	task automatic bus_xfer(input test_t t, output logic [31:0] rdata, output logic ok);
		int i;
		ok = 1'b1;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= '{addr: t.addr, read: t.rd, wdata: t.wdata};
		rsp_ready <= (t.hold == 0);
		@(negedge clk);
		while (!cmd_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
		for (i = 0; i < int'(t.hold); i++) begin
			@(negedge clk);
			if (!rsp_valid || cmd_ready) begin
				$display("bus: response dropped or command ready high while the response is held");
				ok = 1'b0;
			end
			@(posedge clk);
		end
		rsp_ready <= 1'b1;
		@(negedge clk);
		while (!rsp_valid) begin
			@(negedge clk);
		end
		rdata = rsp.rdata;
		@(posedge clk);
	endtask

	// poll the csr until rx_ok
	task automatic wait_rx;
		test_t       poll;
		logic [31:0] v;
		logic        ok;
		poll = '0;
		poll.addr = `UART_CSR_ADDR;
		poll.rd = 1'b1;
		v = '0;
		while (!v[4]) begin
			bus_xfer(poll, v, ok);
		end
	endtask

	initial begin
		logic [31:0] got;
		logic        bus_ok;
		logic        pass;
		int          i;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		rsp_ready = 1'b1;
		flip_en = 1'b0;
		void'($urandom(32'h79751b94));
		for (i = 0; i < 8; i++) begin
			rnd[i] = 8'($urandom());
		end
		// the busy case needs two different bytes
		if (rnd[7] == rnd[6]) begin
			rnd[7] = ~rnd[6];
		end
		build_table();
		limit = tests.size() * (12 * 16 + 50);

		repeat (7) @(posedge clk);
		@(negedge clk);
		if (cmd_ready !== 1'b0 || rsp_valid !== 1'b0 || txd !== 1'b1 || irq !== 1'b0) begin
			$display("reset: outputs are not in their reset state");
			fail_cnt++;
			$display("fail reset");
		end else begin
			pass_cnt++;
			$display("ok   reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;

		for (i = 0; i < tests.size(); i++) begin
			pass = 1'b1;
			flip_en <= tests[i].corrupt;
			repeat (int'(tests[i].settle)) @(posedge clk);
			bus_xfer(tests[i], got, bus_ok);
			if (!bus_ok) begin
				pass = 1'b0;
			end
			if (got !== tests[i].exp) begin
				$display("error %s: expected %h, actual %h", names[i], tests[i].exp, got);
				pass = 1'b0;
			end
			if (tests[i].frame) begin
				wait_rx();
			end
			if (tests[i].irq_chk) begin
				@(negedge clk);
				if (irq !== tests[i].irq_exp) begin
					$display("error %s: expected irq %b, actual %b", names[i],
						tests[i].irq_exp, irq);
					pass = 1'b0;
				end
			end
			if (pass) begin
				pass_cnt++;
				$display("ok   %s", names[i]);
			end else begin
				fail_cnt++;
				$display("fail %s", names[i]);
			end
		end

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/uart_bus_pkg.sv
hw/uart_reg_pkg.sv
hw/uart_ctrl.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
dv/uart_chk.sv
dv/uart_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f filelist.f \
		--top-module uart_tb -o uart_sim
	out="$$(./obj_dir/uart_sim)"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
